// ==== sources.f ====
+incdir+src
+incdir+tb
src/pad_pkg.sv
src/strap_pkg.sv
src/pad_bank.sv
src/usb_overlay.sv
src/strap_sampler.sv
src/io_ring_top.sv
tb/tb_io_ring.sv

// ==== Makefile ====
# Verilator simulation of the I/O ring testbench
# A failing run stops with $fatal, so the sim target returns a non-zero status

VERILATOR ?= verilator
TOP       ?= tb_io_ring
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_io_ring_ref.svh ====
/* Expected pad drive and core input values of the I/O ring, from the pin map rules.
   Included inside the testbench module, after the package imports */
`ifndef TB_IO_RING_REF_SVH
`define TB_IO_RING_REF_SVH

////////////////////
// Pad variants
////////////////////

// MIO banks start at A=0, B=6, C=18, R=30
function automatic pad_variant_e mio_variant(input int idx);
  if ((idx >= 4 && idx <= 5) || (idx >= 14 && idx <= 17) ||
      (idx >= 26 && idx <= 29) || (idx >= 38 && idx <= 43)) begin
    return PAD_OPEN_DRAIN;
  end
  return PAD_BIDIR;
endfunction

function automatic pad_variant_e dio_variant(input int idx);
  if (idx == `DIO_SPI_DEV_SCK || idx == `DIO_SPI_DEV_CSB) begin
    return PAD_INPUT_ONLY;
  end
  if (idx == `DIO_USB_P || idx == `DIO_USB_N) begin
    return PAD_TOLERANT;
  end
  return PAD_BIDIR;
endfunction

// {out, oe} at one pad
function automatic logic [1:0] pad_drive(input pad_variant_e v, input logic out,
                                         input logic oe, input logic inv);
  logic level;
  level = out ^ inv;
  case (v)
    PAD_INPUT_ONLY: return 2'b00;
    PAD_OPEN_DRAIN: return {1'b0, oe && !level};  // Only an enabled low
    default:        return {level, oe};
  endcase
endfunction

////////////////////
// Output side
////////////////////

function automatic mio_core_t drive_mio(input mio_core_t core,
                                       input pad_attr_t [`NUM_MIO-1:0] attr);
  mio_core_t pad;
  logic [1:0] d;
  for (int i = 0; i < `NUM_MIO; i++) begin
    d = pad_drive(mio_variant(i), core.out[i], core.oe[i], attr[i].invert);
    pad.out[i] = d[1];
    pad.oe[i]  = d[0];
  end
  return pad;
endfunction

function automatic dio_core_t drive_dio(input dio_core_t core,
                                       input pad_attr_t [`NUM_DIO-1:0] attr);
  dio_core_t pad;
  logic [1:0] d;
  for (int i = 0; i < `NUM_DIO; i++) begin
    d = pad_drive(dio_variant(i), core.out[i], core.oe[i], attr[i].invert);
    pad.out[i] = d[1];
    pad.oe[i]  = d[0];
  end
  return pad;
endfunction

// TDO owns the SPI device D1 pad while a TAP is selected
function automatic dio_core_t override_tdo(input dio_core_t core, input jtag_rsp_t rsp,
                                          input logic active);
  dio_core_t res;
  res = core;
  if (active) begin
    res.out[`DIO_SPI_DEV_D1] = rsp.tdo;
    res.oe[`DIO_SPI_DEV_D1]  = rsp.tdo_oe;
  end
  return res;
endfunction

function automatic logic [1:0] pullups(input dio_core_t core);
  return {core.out[`DIO_USB_DP_PULLUP] && core.oe[`DIO_USB_DP_PULLUP],
          core.out[`DIO_USB_DN_PULLUP] && core.oe[`DIO_USB_DN_PULLUP]};
endfunction

////////////////////
// Input side
////////////////////

function automatic mio_vec_t sample_mio(input mio_vec_t pad,
                                       input pad_attr_t [`NUM_MIO-1:0] attr);
  mio_vec_t v;
  for (int i = 0; i < `NUM_MIO; i++) begin
    v[i] = pad[i] ^ attr[i].invert;
  end
  return v;
endfunction

// USB data comes from the receiver, not from its own pad
function automatic dio_vec_t sample_dio(input dio_vec_t pad,
                                       input pad_attr_t [`NUM_DIO-1:0] attr,
                                       input logic rx_en, input logic pok);
  dio_vec_t v;
  for (int i = 0; i < `NUM_DIO; i++) begin
    v[i] = pad[i] ^ attr[i].invert;
  end
  v[`DIO_USB_D] = rx_en && pok && pad[`DIO_USB_P] && !pad[`DIO_USB_N];
  return v;
endfunction

function automatic mio_vec_t tie_off_mio(input mio_vec_t sync, input logic active);
  mio_vec_t v;
  v = sync;
  if (active) v[`MIO_TRST_IDX] = 1'b0;
  return v;
endfunction

function automatic dio_vec_t tie_off_dio(input dio_vec_t sync, input logic active);
  dio_vec_t v;
  v = sync;
  if (active) begin
    v[`DIO_SPI_DEV_SCK] = 1'b0;
    v[`DIO_SPI_DEV_CSB] = 1'b1;
    v[`DIO_SPI_DEV_D0]  = 1'b0;
  end
  return v;
endfunction

function automatic jtag_req_t route_jtag(input mio_vec_t sync_m, input dio_vec_t sync_d,
                                        input logic active);
  jtag_req_t j;
  j = '0;
  if (active) begin
    j.tck    = sync_d[`DIO_SPI_DEV_SCK];
    j.tms    = sync_d[`DIO_SPI_DEV_CSB];
    j.trst_n = sync_m[`MIO_TRST_IDX];
    j.tdi    = sync_d[`DIO_SPI_DEV_D0];
  end
  return j;
endfunction

`endif

// ==== tb/tb_io_ring.sv ====
/* Random core, attribute and pad stimulus over three resets, the second with the
   straps on the RV TAP. Outputs are compared at the falling edge */
`timescale 1ns/1ps
`default_nettype none

`include "io_settings.svh"

module tb_io_ring
  import pad_pkg::*;
  import strap_pkg::*;
();

  localparam int CLK_HALF      = 2;  // 4 ns period
  localparam int STIM_DELAY    = 1;
  localparam int RESET_CYCLES  = 10;
  localparam int SETTLE_CYCLES = 6;
  localparam int RUN_CYCLES    = 400;
  localparam int TOTAL_CYCLES  = 3 * (RESET_CYCLES + SETTLE_CYCLES + RUN_CYCLES) + 4;

  logic                     clk_main;
  logic                     arst_n;
  mio_core_t                mio_core;
  dio_core_t                dio_core;
  pad_attr_t [`NUM_MIO-1:0] mio_attr;
  pad_attr_t [`NUM_DIO-1:0] dio_attr;
  mio_vec_t                 mio_in, mio_pad_in, mio_pad_out, mio_pad_oe;
  dio_vec_t                 dio_in, dio_pad_in, dio_pad_out, dio_pad_oe;
  jtag_req_t                jtag_req;
  jtag_rsp_t                jtag_rsp;
  logic                     usb_rx_en, core_pok;
  logic                     pullup_p, pullup_n;
  int                       n_checks = 0;

  io_ring_top dut0 (
    .clk_main_i        (clk_main),
    .arst_n_i          (arst_n),
    .mio_core_i        (mio_core),
    .dio_core_i        (dio_core),
    .mio_attr_i        (mio_attr),
    .dio_attr_i        (dio_attr),
    .mio_in_o          (mio_in),
    .dio_in_o          (dio_in),
    .mio_pad_in_i      (mio_pad_in),
    .mio_pad_out_o     (mio_pad_out),
    .mio_pad_oe_o      (mio_pad_oe),
    .dio_pad_in_i      (dio_pad_in),
    .dio_pad_out_o     (dio_pad_out),
    .dio_pad_oe_o      (dio_pad_oe),
    .jtag_o            (jtag_req),
    .jtag_i            (jtag_rsp),
    .usb_rx_en_i       (usb_rx_en),
    .core_pok_i        (core_pok),
    .usb_pullup_p_en_o (pullup_p),
    .usb_pullup_n_en_o (pullup_n)
  );

`include "tb_io_ring_ref.svh"

  initial begin
    clk_main = 1'b0;
    forever #CLK_HALF clk_main = ~clk_main;
  end

  initial begin : watchdog
    repeat (2 * TOTAL_CYCLES) @(posedge clk_main);
    $display("CHECKS FAILED");
    $fatal(1, "Timeout after %0d cycles, the stimulus never finished", 2 * TOTAL_CYCLES);
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic fail_run(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic check_pads(input mio_core_t got_m, input mio_core_t exp_m,
                            input dio_core_t got_d, input dio_core_t exp_d);
    n_checks++;
    if (got_m !== exp_m) begin
      fail_run($sformatf("MIO pad out/oe %h/%h, expected %h/%h",
                         got_m.out, got_m.oe, exp_m.out, exp_m.oe));
    end else if (got_d !== exp_d) begin
      fail_run($sformatf("DIO pad out/oe %h/%h, expected %h/%h",
                         got_d.out, got_d.oe, exp_d.out, exp_d.oe));
    end
  endtask

  task automatic check_core_in(input mio_vec_t got_m, input mio_vec_t exp_m,
                               input dio_vec_t got_d, input dio_vec_t exp_d);
    n_checks++;
    if (got_m !== exp_m) begin
      fail_run($sformatf("mio_in_o %h, expected %h", got_m, exp_m));
    end else if (got_d !== exp_d) begin
      fail_run($sformatf("dio_in_o %h, expected %h", got_d, exp_d));
    end
  endtask

  task automatic check_jtag(input jtag_req_t got, input jtag_req_t exp);
    n_checks++;
    if (got !== exp) fail_run($sformatf("jtag_o %b, expected %b", got, exp));
  endtask

  task automatic check_usb(input logic [1:0] got, input logic [1:0] exp);
    n_checks++;
    if (got !== exp) fail_run($sformatf("USB pull-ups p/n %b, expected %b", got, exp));
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic mio_vec_t rand_mio();
    logic [63:0] r;
    r = {$urandom(), $urandom()};
    return r[`NUM_MIO-1:0];
  endfunction

  function automatic dio_vec_t rand_dio();
    logic [31:0] r;
    r = $urandom();
    return r[`NUM_DIO-1:0];
  endfunction

  // Quiet pins, straps from the {strap1, strap0} encoding
  task automatic hold_straps(input tap_sel_e sel);
    mio_core   = '0;
    dio_core   = '0;
    mio_attr   = '0;
    dio_attr   = '0;
    mio_pad_in = '0;
    dio_pad_in = '0;
    mio_pad_in[`MIO_STRAP0_IDX] = sel[0];
    mio_pad_in[`MIO_STRAP1_IDX] = sel[1];
    jtag_rsp   = '0;
    usb_rx_en  = 1'b0;
    core_pok   = 1'b0;
  endtask

  task automatic drive_random(input logic [1:0] usb_mode);
    mio_vec_t    inv_m, keep_m;
    dio_vec_t    inv_d, keep_d;
    logic [31:0] r;
    mio_core.out = rand_mio();
    mio_core.oe  = rand_mio();
    dio_core.out = rand_dio();
    dio_core.oe  = rand_dio();
    inv_m  = rand_mio();
    keep_m = rand_mio();
    inv_d  = rand_dio();
    keep_d = rand_dio();
    for (int i = 0; i < `NUM_MIO; i++) begin
      mio_attr[i].invert    = inv_m[i];
      mio_attr[i].pull_keep = keep_m[i];
    end
    for (int i = 0; i < `NUM_DIO; i++) begin
      dio_attr[i].invert    = inv_d[i];
      dio_attr[i].pull_keep = keep_d[i];
    end
    mio_pad_in = rand_mio();  // Straps toggle too
    dio_pad_in = rand_dio();
    r = $urandom();
    jtag_rsp = jtag_rsp_t'(r[1:0]);
    {usb_rx_en, core_pok} = usb_mode;  // Walks all four enable combinations
  endtask

  task automatic apply_reset(input tap_sel_e sel);
    @(posedge clk_main);
    #STIM_DELAY;
    arst_n = 1'b0;
    hold_straps(sel);
    repeat (RESET_CYCLES) @(posedge clk_main);
    #STIM_DELAY;
    arst_n = 1'b1;
    repeat (SETTLE_CYCLES) @(posedge clk_main);  // Straps held through sampling
  endtask

  task automatic run_random();
    for (int c = 0; c < RUN_CYCLES; c++) begin
      @(posedge clk_main);
      #STIM_DELAY;
      drive_random(c[1:0]);
    end
  endtask

  initial begin
    void'($urandom(32'h4138));
    arst_n = 1'b0;
    hold_straps(TAP_NONE);
    apply_reset(TAP_NONE);
    run_random();
    apply_reset(TAP_RV);   // JTAG on the SPI device pins
    run_random();
    apply_reset(TAP_NONE); // Core owns D1 again
    run_random();
    repeat (2) @(posedge clk_main);
    if (n_checks > 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("CHECKS FAILED");
      $fatal(1, "No comparison was made during the run");
    end
  end

  ////////////////////
  // Compare process
  ////////////////////

  initial begin : compare
    mio_vec_t  hist_m1, hist_m2, sync_m;
    dio_vec_t  hist_d1, hist_d2, sync_d;
    tap_sel_e  exp_tap;
    int        since_rst;
    logic      active;
    mio_core_t got_m;
    dio_core_t got_d;
    hist_m1 = '0;
    hist_m2 = '0;
    hist_d1 = '0;
    hist_d2 = '0;
    exp_tap = TAP_NONE;
    since_rst = 0;
    forever begin
      @(negedge clk_main);
      if (!arst_n) begin
        hist_m1 = '0;  // Synchronizers cleared
        hist_m2 = '0;
        hist_d1 = '0;
        hist_d2 = '0;
        exp_tap = TAP_NONE;
        since_rst = 0;
      end
      sync_m = hist_m2;
      sync_d = hist_d2;
      // Straps latched at the third edge after release
      if (since_rst == 2) begin
        exp_tap = tap_sel_e'({sync_m[`MIO_STRAP1_IDX], sync_m[`MIO_STRAP0_IDX]});
      end
      active = (since_rst >= 3) && (exp_tap != TAP_NONE);
      got_m.out = mio_pad_out;
      got_m.oe  = mio_pad_oe;
      got_d.out = dio_pad_out;
      got_d.oe  = dio_pad_oe;
      check_pads(got_m, drive_mio(mio_core, mio_attr),
                 got_d, drive_dio(override_tdo(dio_core, jtag_rsp, active), dio_attr));
      check_jtag(jtag_req, route_jtag(sync_m, sync_d, active));
      check_usb({pullup_p, pullup_n}, pullups(dio_core));
      if (arst_n) begin
        check_core_in(mio_in, tie_off_mio(sync_m, active),
                      dio_in, tie_off_dio(sync_d, active));
        hist_m2 = hist_m1;
        hist_d2 = hist_d1;
        hist_m1 = sample_mio(mio_pad_in, mio_attr);
        hist_d1 = sample_dio(dio_pad_in, dio_attr, usb_rx_en, core_pok);
        since_rst++;
      end
    end
  end

endmodule : tb_io_ring

`default_nettype wire

// ==== src/io_ring_top.sv ====
/* I/O ring between the pads and the core. Pads are split into in, out and oe vectors.
   Variant layout follows the ASIC pinout, open drain on A4-5, B8-11, C8-11, R8-13 */
`timescale 1ns/1ps
`default_nettype none

`include "io_settings.svh"

module io_ring_top
  import pad_pkg::*;
  import strap_pkg::*;
(
  input  logic                     clk_main_i,
  input  logic                     arst_n_i,
  // Core side
  input  mio_core_t                mio_core_i,
  input  dio_core_t                dio_core_i,
  input  pad_attr_t [`NUM_MIO-1:0] mio_attr_i,
  input  pad_attr_t [`NUM_DIO-1:0] dio_attr_i,
  output mio_vec_t                 mio_in_o,
  output dio_vec_t                 dio_in_o,
  // Pad side
  input  mio_vec_t                 mio_pad_in_i,
  output mio_vec_t                 mio_pad_out_o,
  output mio_vec_t                 mio_pad_oe_o,
  input  dio_vec_t                 dio_pad_in_i,
  output dio_vec_t                 dio_pad_out_o,
  output dio_vec_t                 dio_pad_oe_o,
  // JTAG and USB
  output jtag_req_t                jtag_o,
  input  jtag_rsp_t                jtag_i,
  input  logic                     usb_rx_en_i,
  input  logic                     core_pok_i,
  output logic                     usb_pullup_p_en_o,
  output logic                     usb_pullup_n_en_o
);

  // MSB first, bank R down to bank A
  localparam pad_variant_e [`NUM_MIO-1:0] MIO_VARIANT = {
    {6{PAD_OPEN_DRAIN}}, {8{PAD_BIDIR}},  // IOR13..8, IOR7..0
    {4{PAD_OPEN_DRAIN}}, {8{PAD_BIDIR}},  // IOC11..8, IOC7..0
    {4{PAD_OPEN_DRAIN}}, {8{PAD_BIDIR}},  // IOB11..8, IOB7..0
    {2{PAD_OPEN_DRAIN}}, {4{PAD_BIDIR}}   // IOA5..4, IOA3..0
  };

  // SPI device clock and CS_L on top, USB pair at the bottom
  localparam pad_variant_e [`NUM_DIO-1:0] DIO_VARIANT = {
    {2{PAD_INPUT_ONLY}}, {17{PAD_BIDIR}}, {2{PAD_TOLERANT}}
  };

  mio_vec_t  mio_sync;
  dio_vec_t  dio_sync;
  dio_vec_t  dio_usb;      // After the USB substitution
  dio_core_t dio_core_pad; // After the TDO override

  ////////////////////
  // Pad banks
  ////////////////////

  pad_bank #(.NUM_PADS(`NUM_MIO), .VARIANT(MIO_VARIANT)) mio_bank (
    .clk_main_i (clk_main_i),
    .arst_n_i   (arst_n_i),
    .core_out_i (mio_core_i.out),
    .core_oe_i  (mio_core_i.oe),
    .attr_i     (mio_attr_i),
    .core_in_o  (mio_sync),
    .pad_in_i   (mio_pad_in_i),
    .pad_out_o  (mio_pad_out_o),
    .pad_oe_o   (mio_pad_oe_o)
  );

  pad_bank #(.NUM_PADS(`NUM_DIO), .VARIANT(DIO_VARIANT)) dio_bank (
    .clk_main_i (clk_main_i),
    .arst_n_i   (arst_n_i),
    .core_out_i (dio_core_pad.out),
    .core_oe_i  (dio_core_pad.oe),
    .attr_i     (dio_attr_i),
    .core_in_o  (dio_sync),
    .pad_in_i   (dio_pad_in_i),
    .pad_out_o  (dio_pad_out_o),
    .pad_oe_o   (dio_pad_oe_o)
  );

  ////////////////////
  // USB and straps
  ////////////////////

  usb_overlay u_usb_overlay (
    .clk_main_i        (clk_main_i),
    .arst_n_i          (arst_n_i),
    .dio_core_i        (dio_core_i),
    .usb_p_i           (dio_pad_in_i[`DIO_USB_P]),  // Raw pad, not synchronized
    .usb_n_i           (dio_pad_in_i[`DIO_USB_N]),
    .usb_rx_en_i       (usb_rx_en_i),
    .core_pok_i        (core_pok_i),
    .dio_in_i          (dio_sync),
    .dio_in_o          (dio_usb),
    .usb_pullup_p_en_o (usb_pullup_p_en_o),
    .usb_pullup_n_en_o (usb_pullup_n_en_o)
  );

  strap_sampler u_strap_sampler (
    .clk_main_i (clk_main_i),
    .arst_n_i   (arst_n_i),
    .mio_in_i   (mio_sync),
    .dio_in_i   (dio_usb),
    .dio_core_i (dio_core_i),
    .jtag_i     (jtag_i),
    .mio_in_o   (mio_in_o),
    .dio_in_o   (dio_in_o),
    .dio_core_o (dio_core_pad),
    .jtag_o     (jtag_o)
  );

endmodule : io_ring_top

`default_nettype wire

// ==== src/strap_sampler.sv ====
/* TAP straps are sampled once, 3 cycles after reset release, and held until reset.
   Strap values are taken after input invert, as the core would see them */
`timescale 1ns/1ps
`default_nettype none

`include "io_settings.svh"

module strap_sampler
  import pad_pkg::*;
  import strap_pkg::*;
(
  input  logic      clk_main_i,
  input  logic      arst_n_i,
  // Synchronized pad inputs
  input  mio_vec_t  mio_in_i,
  input  dio_vec_t  dio_in_i,
  // Core outputs towards the DIO bank
  input  dio_core_t dio_core_i,
  input  jtag_rsp_t jtag_i,
  // To the core
  output mio_vec_t  mio_in_o,
  output dio_vec_t  dio_in_o,
  // To the pads
  output dio_core_t dio_core_o,
  output jtag_req_t jtag_o
);

  logic [1:0] wait_cnt_q;
  logic       strap_done;
  tap_sel_e   tap_sel_q;
  logic       jtag_active;

  ////////////////////
  // Strap capture
  ////////////////////

  assign strap_done = (wait_cnt_q == 2'd3);

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_cnt_q <= 2'd0;
      tap_sel_q  <= TAP_NONE;
    end else if (!strap_done) begin
      wait_cnt_q <= wait_cnt_q + 2'd1;
      // Sync stages are filled with post-reset pad values by now
      if (wait_cnt_q == 2'd2) begin
        tap_sel_q <= tap_sel_e'({mio_in_i[`MIO_STRAP1_IDX], mio_in_i[`MIO_STRAP0_IDX]});
      end
    end
  end

  assign jtag_active = (tap_sel_q != TAP_NONE);

  ////////////////////
  // JTAG routing
  ////////////////////

  always_comb begin
    jtag_o = '0;
    if (jtag_active) begin
      jtag_o.tck    = dio_in_i[`DIO_SPI_DEV_SCK];
      jtag_o.tms    = dio_in_i[`DIO_SPI_DEV_CSB];
      jtag_o.trst_n = mio_in_i[`MIO_TRST_IDX];
      jtag_o.tdi    = dio_in_i[`DIO_SPI_DEV_D0];
    end
  end

  // Core sees idle SPI and TRST while the TAP owns the pins
  always_comb begin
    mio_in_o = mio_in_i;
    dio_in_o = dio_in_i;
    if (jtag_active) begin
      mio_in_o[`MIO_TRST_IDX]    = 1'b0;
      dio_in_o[`DIO_SPI_DEV_SCK] = 1'b0;
      dio_in_o[`DIO_SPI_DEV_CSB] = 1'b1;  // CSB is active low
      dio_in_o[`DIO_SPI_DEV_D0]  = 1'b0;
    end
  end

  // TDO takes over the SPI device D1 pad
  always_comb begin
    dio_core_o = dio_core_i;
    if (jtag_active) begin
      dio_core_o.out[`DIO_SPI_DEV_D1] = jtag_i.tdo;
      dio_core_o.oe[`DIO_SPI_DEV_D1]  = jtag_i.tdo_oe;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // Selection is frozen for the rest of the reset period
  a_tap_sel_stable: assert property (@(posedge clk_main_i) disable iff (!arst_n_i)
    strap_done |=> $stable(tap_sel_q));

  // No JTAG traffic reaches the TAP before the straps are known
  a_jtag_idle_early: assert property (@(posedge clk_main_i) disable iff (!arst_n_i)
    !strap_done |-> (jtag_o == '0));

endmodule : strap_sampler

`default_nettype wire

// ==== src/usb_overlay.sv ====
/* USB pull-up enables and the gated differential receiver.
   The receiver output is resynchronized and replaces the USB data input */
`timescale 1ns/1ps
`default_nettype none

`include "io_settings.svh"

module usb_overlay
  import pad_pkg::*;
(
  input  logic      clk_main_i,
  input  logic      arst_n_i,
  input  dio_core_t dio_core_i,
  // Raw USB pad pair
  input  logic      usb_p_i,
  input  logic      usb_n_i,
  input  logic      usb_rx_en_i,
  input  logic      core_pok_i,
  // Synchronized inputs from the DIO bank
  input  dio_vec_t  dio_in_i,
  output dio_vec_t  dio_in_o,
  output logic      usb_pullup_p_en_o,
  output logic      usb_pullup_n_en_o
);

  logic usb_diff_rx;
  logic rx_sync_q1, rx_sync_q2;

  ////////////////////
  // Pull-ups
  ////////////////////

  assign usb_pullup_p_en_o = dio_core_i.out[`DIO_USB_DP_PULLUP] &
                             dio_core_i.oe[`DIO_USB_DP_PULLUP];
  assign usb_pullup_n_en_o = dio_core_i.out[`DIO_USB_DN_PULLUP] &
                             dio_core_i.oe[`DIO_USB_DN_PULLUP];

  ////////////////////
  // Diff receiver
  ////////////////////

  // J state only, SE0 and SE1 read as 0
  assign usb_diff_rx = usb_rx_en_i & core_pok_i & usb_p_i & ~usb_n_i;

  // Same two stage delay as the pad synchronizers
  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_sync_q1 <= 1'b0;
      rx_sync_q2 <= 1'b0;
    end else begin
      rx_sync_q1 <= usb_diff_rx;
      rx_sync_q2 <= rx_sync_q1;
    end
  end

  // Substitute the data position, everything else passes
  always_comb begin
    dio_in_o             = dio_in_i;
    dio_in_o[`DIO_USB_D] = rx_sync_q2;
  end

endmodule : usb_overlay

`default_nettype wire

// ==== src/pad_bank.sv ====
/* One bank of pads. The variant is fixed per pad at elaboration.
   Invert is applied before the two input flops, so the core sees it 2 cycles later */
`timescale 1ns/1ps
`default_nettype none

module pad_bank
  import pad_pkg::*;
#(
  parameter int unsigned                NUM_PADS = 1,
  parameter pad_variant_e [NUM_PADS-1:0] VARIANT = {NUM_PADS{PAD_BIDIR}}
) (
  input  logic                       clk_main_i,
  input  logic                       arst_n_i,
  // Core side
  input  logic      [NUM_PADS-1:0]   core_out_i,
  input  logic      [NUM_PADS-1:0]   core_oe_i,
  input  pad_attr_t [NUM_PADS-1:0]   attr_i,
  output logic      [NUM_PADS-1:0]   core_in_o,
  // Pad side
  input  logic      [NUM_PADS-1:0]   pad_in_i,
  output logic      [NUM_PADS-1:0]   pad_out_o,
  output logic      [NUM_PADS-1:0]   pad_oe_o
);

  logic [NUM_PADS-1:0] pad_in_eff;
  logic [NUM_PADS-1:0] sync_q1, sync_q2;

  ////////////////////
  // Per pad drivers
  ////////////////////

  for (genvar i = 0; i < NUM_PADS; i++) begin : gen_pad
    assign pad_in_eff[i] = pad_in_i[i] ^ attr_i[i].invert;

    if (VARIANT[i] == PAD_OPEN_DRAIN) begin : gen_open_drain
      // Pull low only for an enabled zero
      assign pad_out_o[i] = 1'b0;
      assign pad_oe_o[i]  = core_oe_i[i] & ~(core_out_i[i] ^ attr_i[i].invert);
    end else if (VARIANT[i] == PAD_INPUT_ONLY) begin : gen_input_only
      assign pad_out_o[i] = 1'b0;
      assign pad_oe_o[i]  = 1'b0;  // No output driver
    end else begin : gen_push_pull
      // Bidir and tolerant drive both levels
      assign pad_out_o[i] = core_out_i[i] ^ attr_i[i].invert;
      assign pad_oe_o[i]  = core_oe_i[i];
    end
  end

  ////////////////////
  // Input sync
  ////////////////////

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= pad_in_eff;
      sync_q2 <= sync_q1;
    end
  end

  assign core_in_o = sync_q2;

endmodule : pad_bank

`default_nettype wire

// ==== src/strap_pkg.sv ====
/* TAP selection and JTAG types for the strap sampler.
   tap_sel_e is encoded as {strap1, strap0} */
`default_nettype none

package strap_pkg;

  ////////////////////
  // TAP selection
  ////////////////////

  typedef enum logic [1:0] {
    TAP_NONE = 2'b00,  // Pins stay with the core
    TAP_LC   = 2'b01,
    TAP_RV   = 2'b10,
    TAP_DFT  = 2'b11
  } tap_sel_e;

  ////////////////////
  // JTAG signals
  ////////////////////

  // Routed from the pads towards the TAP
  typedef struct packed {
    logic tck;
    logic tms;
    logic trst_n;
    logic tdi;
  } jtag_req_t;

  // Returned from the TAP to the TDO pad
  typedef struct packed {
    logic tdo;
    logic tdo_oe;
  } jtag_rsp_t;

endpackage : strap_pkg

`default_nettype wire

// ==== src/pad_pkg.sv ====
/* Pad level types shared by the banks and the top level.
   pull_keep is carried through but has no effect in this model */
`default_nettype none

`include "io_settings.svh"

package pad_pkg;

  ////////////////////
  // Pad variants
  ////////////////////

  typedef enum logic [1:0] {
    PAD_BIDIR      = `PAD_VAR_BIDIR,
    PAD_INPUT_ONLY = `PAD_VAR_INPUT_ONLY,
    PAD_TOLERANT   = `PAD_VAR_TOLERANT,
    PAD_OPEN_DRAIN = `PAD_VAR_OPEN_DRAIN
  } pad_variant_e;

  // Per pad attribute, invert sits in bit 0
  typedef struct packed {
    logic [`ATTR_W-2:0] pull_keep;  // Remaining attribute bits, no function here
    logic               invert;     // Applies to output and input path
  } pad_attr_t;

  ////////////////////
  // Pad vectors
  ////////////////////

  typedef logic [`NUM_MIO-1:0] mio_vec_t;
  typedef logic [`NUM_DIO-1:0] dio_vec_t;

  // Core side output and enable, muxed pads
  typedef struct packed {
    mio_vec_t out;
    mio_vec_t oe;
  } mio_core_t;

  // Same layout for the dedicated pads
  typedef struct packed {
    dio_vec_t out;
    dio_vec_t oe;
  } dio_core_t;

endpackage : pad_pkg

`default_nettype wire

// ==== src/io_settings.svh ====
/* Pad counts, attribute width, pad variant codes and pin map of the I/O ring.
   DIO positions follow the dedicated pad order of the pinout, USB_N at bit 0 */
`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH

////////////////////
// Pad counts
////////////////////

`define NUM_MIO 44
`define NUM_DIO 21
`define ATTR_W  2   // invert plus pull/keep

// Pad variant encodings
`define PAD_VAR_BIDIR      2'd0
`define PAD_VAR_INPUT_ONLY 2'd1
`define PAD_VAR_TOLERANT   2'd2
`define PAD_VAR_OPEN_DRAIN 2'd3

////////////////////
// MIO pin map
////////////////////

`define MIO_STRAP0_IDX 26  // IOC8
`define MIO_STRAP1_IDX 23  // IOC5
`define MIO_TRST_IDX   18  // IOC0

////////////////////
// DIO pin map
////////////////////

`define DIO_USB_N          0
`define DIO_USB_P          1
`define DIO_USB_D          2   // Replaced by the differential receiver
`define DIO_USB_DN_PULLUP  5
`define DIO_USB_DP_PULLUP  6

// SPI device pins double as the JTAG port
`define DIO_SPI_DEV_D0     15  // TDI
`define DIO_SPI_DEV_D1     16  // TDO
`define DIO_SPI_DEV_CSB    19  // TMS
`define DIO_SPI_DEV_SCK    20  // TCK

`endif
